// ==== hdl/sparc_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sparc_params.svh"

module sparc_alu (
	input  sparc_pkg::alu_op_t        op,
	input  logic [`SPARC_XLEN-1:0]    a,
	input  logic [`SPARC_XLEN-1:0]    b,
	output logic [`SPARC_XLEN-1:0]    result,
	output logic                      n,
	output logic                      z,
	output logic                      v,
	output logic                      c
);

	logic                   sub_op;
	logic                   arith;
	logic [`SPARC_XLEN-1:0] b_eff;
	logic [`SPARC_XLEN:0]   sum;    // Extra bit holds the carry out

	always_comb begin
		sub_op = (op == sparc_pkg::alu_sub) || (op == sparc_pkg::alu_subcc);
		arith  = sub_op || (op == sparc_pkg::alu_add) || (op == sparc_pkg::alu_addcc);
		b_eff  = sub_op ? ~b : b;    // Two's complement subtract
		sum    = {1'b0, a} + {1'b0, b_eff} + {{`SPARC_XLEN{1'b0}}, sub_op};

		case (op)
			sparc_pkg::alu_and: result = a & b;
			sparc_pkg::alu_or:  result = a | b;
			sparc_pkg::alu_xor: result = a ^ b;
			default:            result = sum[`SPARC_XLEN-1:0];
		endcase

		// icc flags
		n = result[`SPARC_XLEN-1];
		z = (result == '0);
		if (arith) begin
			// Operands agree in sign and the result does not
			v = (a[`SPARC_XLEN-1] == b_eff[`SPARC_XLEN-1]) &&
				(result[`SPARC_XLEN-1] != a[`SPARC_XLEN-1]);
			c = sum[`SPARC_XLEN] ^ sub_op;    // Borrow on subtract
		end else begin
			v = 1'b0;    // Logic ops clear V and C
			c = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/sparc_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sparc_params.svh"

module sparc_control (
	input  logic                              Clk,
	input  logic                              RESET,
	input  sparc_pkg::sparc_instr_t           ir,
	input  logic                              psr_z,
	input  logic                              wb_ack,
	output logic                              wb_cyc,
	output logic                              wb_stb,
	output logic                              wb_we,
	output logic                              ir_en,
	output logic                              pc_en,
	output logic                              npc_en,
	output logic                              mar_en,
	output logic                              mdr_en,
	output logic                              rf_we,
	output logic                              psr_en,
	output sparc_pkg::a_sel_t                 a_sel,
	output sparc_pkg::b_sel_t                 b_sel,
	output sparc_pkg::ext_sel_t               ext_sel,
	output sparc_pkg::pc_sel_t                pc_sel,
	output sparc_pkg::adr_sel_t               adr_sel,
	output logic                              mdr_sel,   // 1 loads MDR from port A
	output logic [$clog2(`SPARC_NREGS)-1:0]   rs_a,
	output logic [$clog2(`SPARC_NREGS)-1:0]   rs_b,
	output logic [$clog2(`SPARC_NREGS)-1:0]   rd,
	output sparc_pkg::alu_op_t                alu_op
);

	localparam logic [2:0] st_fetch     = 3'd0;
	localparam logic [2:0] st_execute   = 3'd1;
	localparam logic [2:0] st_mem_addr  = 3'd2;
	localparam logic [2:0] st_mem_bus   = 3'd3;
	localparam logic [2:0] st_writeback = 3'd4;
	localparam logic [2:0] st_link      = 3'd5;

	logic [2:0] state;
	logic is_sethi, is_bicc, is_call, is_jmpl;
	logic is_alu, is_cc, is_ld, is_st;
	logic taken;

	// Instruction class decode
	always_comb begin
		is_sethi = (ir.fmt2.op == 2'b00) && (ir.fmt2.op2 == 3'b100);
		is_bicc  = (ir.fmt2.op == 2'b00) && (ir.fmt2.op2 == 3'b010);
		is_call  = (ir.fmt1.op == 2'b01);
		is_jmpl  = (ir.fmt3_reg.op == 2'b10) && (ir.fmt3_reg.op3 == 6'h38);
		is_ld    = (ir.fmt3_reg.op == 2'b11) && (ir.fmt3_reg.op3 == 6'h00);
		is_st    = (ir.fmt3_reg.op == 2'b11) && (ir.fmt3_reg.op3 == 6'h04);
		is_alu   = 1'b0;
		if (ir.fmt3_reg.op == 2'b10) begin
			case (ir.fmt3_reg.op3)
				sparc_pkg::alu_add,
				sparc_pkg::alu_and,
				sparc_pkg::alu_or,
				sparc_pkg::alu_xor,
				sparc_pkg::alu_sub,
				sparc_pkg::alu_addcc,
				sparc_pkg::alu_subcc: is_alu = 1'b1;
				default:              is_alu = 1'b0;  // Runs as a no-op
			endcase
		end
		is_cc = is_alu && (ir.fmt3_reg.op3 == sparc_pkg::alu_addcc ||
			ir.fmt3_reg.op3 == sparc_pkg::alu_subcc);
		// cond sits below the annul bit
		case (ir.fmt2.rd[3:0])
			4'b1000: taken = 1'b1;    // ba
			4'b0001: taken = psr_z;   // be
			4'b1001: taken = !psr_z;  // bne
			default: taken = 1'b0;    // bn and the unsupported conditions
		endcase
	end

	// Sequencer and registered bus cycle controls
	always_ff @(posedge Clk) begin
		if (RESET) begin
			state  <= st_fetch;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we  <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (!wb_cyc) begin  // After RESET or a store
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
					end else if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						state  <= st_execute;
					end
				end
				st_execute: begin
					if (is_ld || is_st) begin
						state <= st_mem_addr;
					end else if (is_call || is_jmpl) begin
						state <= st_link;
					end else begin
						state  <= st_fetch;
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
					end
				end
				st_mem_addr: begin
					state  <= st_mem_bus;
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
					wb_we  <= is_st;
				end
				st_mem_bus: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we  <= 1'b0;
						state  <= is_ld ? st_writeback : st_fetch;
					end
				end
				default: begin  // writeback and link
					state  <= st_fetch;
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
				end
			endcase
		end
	end

	// Datapath controls per state
	always_comb begin
		ir_en   = 1'b0;
		pc_en   = 1'b0;
		npc_en  = 1'b0;
		mar_en  = 1'b0;
		mdr_en  = 1'b0;
		rf_we   = 1'b0;
		psr_en  = 1'b0;
		a_sel   = sparc_pkg::a_reg;
		b_sel   = ir.fmt3_imm.i ? sparc_pkg::b_ext : sparc_pkg::b_reg;
		ext_sel = sparc_pkg::ext_simm13;
		pc_sel  = sparc_pkg::pc_npc;  // PC always takes the old nPC
		adr_sel = sparc_pkg::adr_pc;
		mdr_sel = 1'b0;
		rs_a    = ir.fmt3_reg.rs1;
		rs_b    = ir.fmt3_reg.rs2;
		rd      = ir.fmt3_reg.rd;
		alu_op  = sparc_pkg::alu_add;
		case (state)
			st_fetch: ir_en = wb_cyc && wb_ack;
			st_execute: begin
				pc_en = !(is_call || is_jmpl);  // Transfers step PC in link
				if (is_sethi) begin
					rs_a    = '0;
					b_sel   = sparc_pkg::b_ext;
					ext_sel = sparc_pkg::ext_sethi;
					rf_we   = 1'b1;
				end else if (is_bicc) begin
					a_sel   = sparc_pkg::a_pc;      // Target is PC relative
					b_sel   = sparc_pkg::b_ext;
					ext_sel = sparc_pkg::ext_disp22;
					npc_en  = taken;
				end else if (is_call || is_jmpl) begin
					rs_a  = '0;                    // Link value r0 + PC
					b_sel = sparc_pkg::b_pc;
					rf_we = 1'b1;
					if (is_call)
						rd = 5'd15;
				end else if (is_alu) begin
					alu_op = sparc_pkg::alu_op_t'(ir.fmt3_reg.op3);
					rf_we  = 1'b1;
					psr_en = is_cc;
				end else if (is_ld || is_st) begin
					mar_en = 1'b1;                 // rs1 plus rs2 or simm13
				end
			end
			st_mem_addr: begin
				rs_a    = ir.fmt3_reg.rd;          // Store data
				mdr_sel = 1'b1;
				mdr_en  = is_st;
			end
			st_mem_bus: begin
				adr_sel = sparc_pkg::adr_mar;
				mdr_en  = is_ld && wb_cyc && wb_ack;
			end
			st_writeback: begin
				rs_a  = '0;
				b_sel = sparc_pkg::b_mdr;
				rf_we = 1'b1;
			end
			st_link: begin
				pc_en  = 1'b1;
				npc_en = 1'b1;
				if (is_call) begin
					a_sel   = sparc_pkg::a_pc;
					b_sel   = sparc_pkg::b_ext;
					ext_sel = sparc_pkg::ext_disp30;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/sparc_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sparc_params.svh"

module sparc_core (
	input  logic                      Clk,
	input  logic                      RESET,
	output logic                      wb_cyc,
	output logic                      wb_stb,
	output logic                      wb_we,
	output logic [`SPARC_XLEN-1:0]    wb_adr,
	output logic [`SPARC_XLEN-1:0]    wb_dat_w,
	input  logic [`SPARC_XLEN-1:0]    wb_dat_r,
	input  logic                      wb_ack
);

	sparc_pkg::sparc_instr_t             ir;
	logic                                psr_z;
	logic                                ir_en, pc_en, npc_en, mar_en, mdr_en;
	logic                                rf_we, psr_en, mdr_sel;
	sparc_pkg::a_sel_t                   a_sel;
	sparc_pkg::b_sel_t                   b_sel;
	sparc_pkg::ext_sel_t                 ext_sel;
	sparc_pkg::pc_sel_t                  pc_sel;
	sparc_pkg::adr_sel_t                 adr_sel;
	logic [$clog2(`SPARC_NREGS)-1:0]     rs_a, rs_b, rd;
	sparc_pkg::alu_op_t                  alu_op;

	// Sequencer, the only user of wb_ack
	sparc_control u_control (
		.Clk     (Clk),
		.RESET   (RESET),
		.ir      (ir),
		.psr_z   (psr_z),
		.wb_ack  (wb_ack),
		.wb_cyc  (wb_cyc),
		.wb_stb  (wb_stb),
		.wb_we   (wb_we),
		.ir_en   (ir_en),
		.pc_en   (pc_en),
		.npc_en  (npc_en),
		.mar_en  (mar_en),
		.mdr_en  (mdr_en),
		.rf_we   (rf_we),
		.psr_en  (psr_en),
		.a_sel   (a_sel),
		.b_sel   (b_sel),
		.ext_sel (ext_sel),
		.pc_sel  (pc_sel),
		.adr_sel (adr_sel),
		.mdr_sel (mdr_sel),
		.rs_a    (rs_a),
		.rs_b    (rs_b),
		.rd      (rd),
		.alu_op  (alu_op)
	);

	sparc_datapath u_datapath (
		.Clk      (Clk),
		.RESET    (RESET),
		.ir_en    (ir_en),
		.pc_en    (pc_en),
		.npc_en   (npc_en),
		.mar_en   (mar_en),
		.mdr_en   (mdr_en),
		.rf_we    (rf_we),
		.psr_en   (psr_en),
		.a_sel    (a_sel),
		.b_sel    (b_sel),
		.ext_sel  (ext_sel),
		.pc_sel   (pc_sel),
		.adr_sel  (adr_sel),
		.mdr_sel  (mdr_sel),
		.rs_a     (rs_a),
		.rs_b     (rs_b),
		.rd       (rd),
		.alu_op   (alu_op),
		.wb_dat_r (wb_dat_r),
		.ir       (ir),
		.psr_z    (psr_z),
		.wb_adr   (wb_adr),     // PC or MAR
		.wb_dat_w (wb_dat_w)    // MDR
	);

endmodule

`default_nettype wire

// ==== hdl/sparc_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sparc_params.svh"

module sparc_datapath (
	input  logic                              Clk,
	input  logic                              RESET,
	input  logic                              ir_en,
	input  logic                              pc_en,
	input  logic                              npc_en,
	input  logic                              mar_en,
	input  logic                              mdr_en,
	input  logic                              rf_we,
	input  logic                              psr_en,
	input  sparc_pkg::a_sel_t                 a_sel,
	input  sparc_pkg::b_sel_t                 b_sel,
	input  sparc_pkg::ext_sel_t               ext_sel,
	input  sparc_pkg::pc_sel_t                pc_sel,
	input  sparc_pkg::adr_sel_t               adr_sel,
	input  logic                              mdr_sel,
	input  logic [$clog2(`SPARC_NREGS)-1:0]   rs_a,
	input  logic [$clog2(`SPARC_NREGS)-1:0]   rs_b,
	input  logic [$clog2(`SPARC_NREGS)-1:0]   rd,
	input  sparc_pkg::alu_op_t                alu_op,
	input  logic [`SPARC_XLEN-1:0]            wb_dat_r,
	output sparc_pkg::sparc_instr_t           ir,
	output logic                              psr_z,
	output logic [`SPARC_XLEN-1:0]            wb_adr,
	output logic [`SPARC_XLEN-1:0]            wb_dat_w
);

	logic [`SPARC_XLEN-1:0] pc, npc;
	logic [`SPARC_XLEN-1:0] mar, mdr;
	logic [3:0]             psr_icc;    // N Z V C
	logic [`SPARC_XLEN-1:0] rdata_a, rdata_b;
	logic [`SPARC_XLEN-1:0] ext;
	logic [`SPARC_XLEN-1:0] alu_a, alu_b, alu_result;
	logic                   alu_n, alu_z, alu_v, alu_c;

	sparc_regfile u_regfile (
		.Clk     (Clk),
		.RESET   (RESET),
		.rs_a    (rs_a),
		.rs_b    (rs_b),
		.rd      (rd),
		.we      (rf_we),
		.wdata   (alu_result),   // Every register write passes the ALU
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	// Operand extender
	always_comb begin
		case (ext_sel)
			sparc_pkg::ext_simm13: ext = {{19{ir.fmt3_imm.simm13[12]}}, ir.fmt3_imm.simm13};
			sparc_pkg::ext_sethi:  ext = {ir.fmt2.imm22, 10'b0};
			sparc_pkg::ext_disp22: ext = {{8{ir.fmt2.imm22[21]}}, ir.fmt2.imm22, 2'b00};
			default:               ext = {ir.fmt1.disp30, 2'b00};
		endcase
	end

	// ALU operand muxes
	assign alu_a = (a_sel == sparc_pkg::a_pc) ? pc : rdata_a;
	always_comb begin
		case (b_sel)
			sparc_pkg::b_reg: alu_b = rdata_b;
			sparc_pkg::b_ext: alu_b = ext;
			sparc_pkg::b_pc:  alu_b = pc;
			default:          alu_b = mdr;
		endcase
	end

	sparc_alu u_alu (
		.op     (alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result),
		.n      (alu_n),
		.z      (alu_z),
		.v      (alu_v),
		.c      (alu_c)
	);

	// Program counters and flags
	always_ff @(posedge Clk) begin
		if (RESET) begin
			pc      <= `SPARC_RESET_PC;
			npc     <= `SPARC_RESET_PC + `SPARC_XLEN'd4;
			psr_icc <= '0;
		end else begin
			if (pc_en)
				pc <= (pc_sel == sparc_pkg::pc_npc) ? npc : alu_result;
			if (npc_en)
				npc <= alu_result;          // Taken transfer
			else if (pc_en)
				npc <= npc + `SPARC_XLEN'd4;
			if (psr_en)
				psr_icc <= {alu_n, alu_z, alu_v, alu_c};
		end
	end

	// IR, MAR and MDR
	always_ff @(posedge Clk) begin
		if (ir_en)
			ir <= wb_dat_r;
		if (mar_en)
			mar <= alu_result;
		if (mdr_en)
			mdr <= mdr_sel ? rdata_a : wb_dat_r;    // Store data or load data
	end

	assign psr_z    = psr_icc[2];
	assign wb_adr   = (adr_sel == sparc_pkg::adr_pc) ? pc : mar;
	assign wb_dat_w = mdr;

endmodule

`default_nettype wire

// ==== hdl/sparc_params.svh ====
`ifndef SPARC_PARAMS_SVH
`define SPARC_PARAMS_SVH

// Core wide constants shared by the RTL files

// Data path and bus address width
`define SPARC_XLEN 32

// Integer registers, r0 reads as zero
// 32 of them gives 5 bit register numbers
`define SPARC_NREGS 32

// First fetch address after RESET
// nPC starts one word above it
// Must stay word aligned
`define SPARC_RESET_PC 32'h0000_0000

`endif

// ==== hdl/sparc_pkg.sv ====
`default_nettype none

package sparc_pkg;

	// One instruction word, seen through its three SPARC formats
	typedef union packed {
		struct packed {
			logic [1:0]  op;      // 01 for call
			logic [29:0] disp30;  // Word displacement
		} fmt1;
		struct packed {
			logic [1:0]  op;
			logic [4:0]  rd;      // Annul bit and cond in branches
			logic [2:0]  op2;     // 100 sethi, 010 Bicc
			logic [21:0] imm22;
		} fmt2;
		struct packed {
			logic [1:0] op;
			logic [4:0] rd;
			logic [5:0] op3;
			logic [4:0] rs1;
			logic       i;       // Clear here
			logic [7:0] asi;     // Ignored
			logic [4:0] rs2;
		} fmt3_reg;
		struct packed {
			logic [1:0]  op;
			logic [4:0]  rd;
			logic [5:0]  op3;
			logic [4:0]  rs1;
			logic        i;      // Set here
			logic [12:0] simm13;
		} fmt3_imm;
	} sparc_instr_t;

	// Encoded as the matching op3 values
	typedef enum logic [5:0] {
		alu_add   = 6'h00,
		alu_and   = 6'h01,
		alu_or    = 6'h02,
		alu_xor   = 6'h03,
		alu_sub   = 6'h04,
		alu_addcc = 6'h10,
		alu_subcc = 6'h14
	} alu_op_t;

	typedef enum logic [1:0] {
		ext_simm13,  // Sign extended simm13
		ext_sethi,   // imm22 in the top bits
		ext_disp22,  // Branch displacement in bytes
		ext_disp30   // Call displacement in bytes
	} ext_sel_t;

	typedef enum logic [1:0] {b_reg, b_ext, b_pc, b_mdr} b_sel_t;
	typedef enum logic {a_reg, a_pc} a_sel_t;
	typedef enum logic {pc_npc, pc_alu} pc_sel_t;
	typedef enum logic {adr_pc, adr_mar} adr_sel_t;

endpackage

`default_nettype wire

// ==== hdl/sparc_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sparc_params.svh"

module sparc_regfile (
	input  logic                              Clk,
	input  logic                              RESET,
	input  logic [$clog2(`SPARC_NREGS)-1:0]   rs_a,
	input  logic [$clog2(`SPARC_NREGS)-1:0]   rs_b,
	input  logic [$clog2(`SPARC_NREGS)-1:0]   rd,
	input  logic                              we,
	input  logic [`SPARC_XLEN-1:0]            wdata,
	output logic [`SPARC_XLEN-1:0]            rdata_a,
	output logic [`SPARC_XLEN-1:0]            rdata_b
);

	logic [`SPARC_XLEN-1:0] regs [`SPARC_NREGS];

	// Write port, r0 never written
	always_ff @(posedge Clk) begin
		if (RESET) begin
			for (int k = 0; k < `SPARC_NREGS; k++)
				regs[k] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// Asynchronous read ports
	assign rdata_a = (rs_a == '0) ? '0 : regs[rs_a];
	assign rdata_b = (rs_b == '0) ? '0 : regs[rs_b];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module sparc_core_tb -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
	exit 0
else
	exit 1
fi

// ==== tb.f ====
+incdir+hdl
hdl/sparc_pkg.sv
hdl/sparc_alu.sv
hdl/sparc_regfile.sv
hdl/sparc_datapath.sv
hdl/sparc_control.sv
hdl/sparc_core.sv
verif/tb_clock.sv
verif/sparc_core_asserts.sv
verif/sparc_core_tb.sv

// ==== verif/sparc_core_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module sparc_core_asserts (
	input logic        Clk,
	input logic        RESET,
	input logic        wb_cyc,
	input logic        wb_stb,
	input logic        wb_we,
	input logic [31:0] wb_adr,
	input logic [31:0] wb_dat_w,
	input logic        wb_ack
);

	// Strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge Clk) disable iff (RESET) wb_stb |-> wb_cyc)
		else $error("wb_stb high without wb_cyc");

	// Master holds the request until ack
	req_stable: assert property (@(posedge Clk) disable iff (RESET)
		(wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)))
		else $error("Request changed while waiting for ack");

	bus_idle_in_reset: assert property (@(posedge Clk) RESET |=> !wb_cyc)
		else $error("wb_cyc high during RESET");

	adr_aligned: assert property (@(posedge Clk) disable iff (RESET)
		wb_stb |-> (wb_adr[1:0] == 2'b00))
		else $error("Unaligned bus address");

endmodule

bind sparc_core sparc_core_asserts u_asserts (
	.Clk      (Clk),
	.RESET    (RESET),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_we    (wb_we),
	.wb_adr   (wb_adr),
	.wb_dat_w (wb_dat_w),
	.wb_ack   (wb_ack)
);

`default_nettype wire

// ==== verif/sparc_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sparc_core_tb;

	localparam int NTESTS = 6;
	localparam logic [31:0] NOP = 32'h0100_0000;    // sethi 0 to r0

	logic        Clk, RESET;
	logic        rst_req = 1'b0;
	logic        wb_cyc, wb_stb, wb_we;
	logic [31:0] wb_adr, wb_dat_w;
	logic [31:0] wb_dat_r = '0;
	logic        wb_ack = 1'b0;

	logic [31:0] image [256];    // Loaded into mem during RESET
	logic [31:0] mem [256];
	logic [31:0] store_adr [$];  // Write log
	logic [31:0] store_dat [$];
	logic [31:0] lcg_state = 32'd25850;
	logic [1:0]  waits = 2'd0;

	// Test table
	string       test_name [NTESTS];
	logic [31:0] test_prog [NTESTS][10];
	logic [31:0] test_data [NTESTS];
	int          test_nst  [NTESTS];
	logic [31:0] exp_adr   [NTESTS][3];
	logic [31:0] exp_dat   [NTESTS][3];

	int n_pass = 0;
	int n_fail = 0;

	tb_clock u_clock (.rst_req(rst_req), .Clk(Clk), .RESET(RESET));

	sparc_core DUT (
		.Clk      (Clk),
		.RESET    (RESET),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	function automatic logic [1:0] next_wait();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[29:28];    // 0 to 3 wait cycles
	endfunction

	// Instruction encoders from the SPARC formats
	function automatic logic [31:0] reg_form(logic [1:0] op, logic [4:0] rd,
		logic [5:0] op3, logic [4:0] rs1, logic [4:0] rs2);
		return {op, rd, op3, rs1, 1'b0, 8'h00, rs2};
	endfunction

	function automatic logic [31:0] imm_form(logic [1:0] op, logic [4:0] rd,
		logic [5:0] op3, logic [4:0] rs1, logic [12:0] simm);
		return {op, rd, op3, rs1, 1'b1, simm};
	endfunction

	function automatic logic [31:0] sethi_word(logic [4:0] rd, logic [21:0] imm);
		return {2'b00, rd, 3'b100, imm};
	endfunction

	function automatic logic [31:0] branch_word(logic [3:0] cond, logic [21:0] disp);
		return {2'b00, 1'b0, cond, 3'b010, disp};
	endfunction

	function automatic logic [31:0] call_word(logic [29:0] disp);
		return {2'b01, disp};
	endfunction

	// Wishbone slave with random wait states
	always @(posedge Clk) begin
		if (RESET) begin
			wb_ack <= 1'b0;
			waits  <= next_wait();
			for (int k = 0; k < 256; k++)
				mem[k] <= image[k];
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
			waits  <= next_wait();
		end else if (wb_cyc && wb_stb) begin
			if (waits == 2'd0) begin
				wb_ack   <= 1'b1;
				wb_dat_r <= mem[wb_adr[9:2]];
				if (wb_we) begin
					mem[wb_adr[9:2]] <= wb_dat_w;
					store_adr.push_back(wb_adr);
					store_dat.push_back(wb_dat_w);
				end
			end else begin
				waits <= waits - 2'd1;
			end
		end
	end

	task automatic build_table();
		for (int t = 0; t < NTESTS; t++) begin
			test_data[t] = 32'h0;
			for (int w = 0; w < 10; w++)
				test_prog[t][w] = NOP;
		end
		test_name[0] = "alu_ops";
		test_prog[0][0] = imm_form(2, 1, 6'h02, 0, 13'h123);  // or r1 = 0x123
		test_prog[0][1] = imm_form(2, 2, 6'h00, 1, 13'h0ff);  // add r2 = 0x222
		test_prog[0][2] = reg_form(2, 3, 6'h04, 2, 1);        // sub r3 = 0xff
		test_prog[0][3] = reg_form(2, 4, 6'h01, 2, 3);        // and r4 = 0x22
		test_prog[0][4] = imm_form(2, 0, 6'h03, 4, 13'h007);  // xor into r0
		test_prog[0][5] = imm_form(3, 3, 6'h04, 0, 13'h100);
		test_prog[0][6] = imm_form(3, 4, 6'h04, 0, 13'h104);
		test_prog[0][7] = imm_form(3, 0, 6'h04, 0, 13'h108);
		test_prog[0][8] = branch_word(4'b1000, 22'd0);
		test_nst[0] = 3;
		exp_adr[0] = '{32'h100, 32'h104, 32'h108};
		exp_dat[0] = '{32'h0ff, 32'h022, 32'h000};

		test_name[1] = "xor_sub_r0";
		test_prog[1][0] = imm_form(2, 1, 6'h02, 0, 13'h5a5);
		test_prog[1][1] = imm_form(2, 2, 6'h03, 1, 13'h0ff);  // 0x55a
		test_prog[1][2] = reg_form(2, 0, 6'h00, 1, 1);        // r0 stays zero
		test_prog[1][3] = reg_form(2, 3, 6'h04, 0, 1);        // Negative result
		test_prog[1][4] = imm_form(3, 2, 6'h04, 0, 13'h100);
		test_prog[1][5] = imm_form(3, 0, 6'h04, 0, 13'h104);
		test_prog[1][6] = imm_form(3, 3, 6'h04, 0, 13'h108);
		test_prog[1][7] = branch_word(4'b1000, 22'd0);
		test_nst[1] = 3;
		exp_adr[1] = '{32'h100, 32'h104, 32'h108};
		exp_dat[1] = '{32'h0000_055a, 32'h0, 32'hffff_fa5b};

		test_name[2] = "sethi_or";
		test_prog[2][0] = sethi_word(1, 22'h12345);
		test_prog[2][1] = imm_form(2, 1, 6'h02, 1, 13'h2ab);
		test_prog[2][2] = sethi_word(2, 22'h3fffff);
		test_prog[2][3] = imm_form(3, 1, 6'h04, 0, 13'h100);
		test_prog[2][4] = imm_form(3, 2, 6'h04, 0, 13'h104);
		test_prog[2][5] = branch_word(4'b1000, 22'd0);
		test_nst[2] = 2;
		exp_adr[2] = '{32'h100, 32'h104, 32'h0};
		exp_dat[2] = '{32'h048d_16ab, 32'hffff_fc00, 32'h0};

		test_name[3] = "ld_st";
		test_data[3] = 32'hcafe_f00d;
		test_prog[3][0] = imm_form(3, 1, 6'h00, 0, 13'h080);  // ld r1
		test_prog[3][1] = imm_form(3, 1, 6'h04, 0, 13'h104);
		test_prog[3][2] = imm_form(2, 2, 6'h00, 1, 13'h001);
		test_prog[3][3] = imm_form(3, 2, 6'h04, 0, 13'h108);
		test_prog[3][4] = branch_word(4'b1000, 22'd0);
		test_nst[3] = 2;
		exp_adr[3] = '{32'h104, 32'h108, 32'h0};
		exp_dat[3] = '{32'hcafe_f00d, 32'hcafe_f00e, 32'h0};

		test_name[4] = "be_bne";
		test_prog[4][0] = imm_form(2, 0, 6'h14, 0, 13'h000);  // subcc sets Z
		test_prog[4][1] = branch_word(4'b0001, 22'd3);        // be to 0x10
		test_prog[4][2] = imm_form(2, 2, 6'h02, 0, 13'h011);  // Delay slot
		test_prog[4][3] = imm_form(2, 2, 6'h02, 2, 13'h700);  // Skipped
		test_prog[4][4] = branch_word(4'b1001, 22'd3);        // bne not taken
		test_prog[4][5] = imm_form(2, 2, 6'h02, 2, 13'h022);  // Delay slot
		test_prog[4][6] = imm_form(2, 2, 6'h02, 2, 13'h100);  // Fall through
		test_prog[4][7] = imm_form(3, 2, 6'h04, 0, 13'h100);
		test_prog[4][8] = branch_word(4'b1000, 22'd0);
		test_nst[4] = 1;
		exp_adr[4] = '{32'h100, 32'h0, 32'h0};
		exp_dat[4] = '{32'h133, 32'h0, 32'h0};

		test_name[5] = "call_jmpl";
		test_prog[5][1] = call_word(30'd6);                   // To 0x1c with r15 = 4
		test_prog[5][2] = imm_form(2, 1, 6'h02, 0, 13'h044);
		test_prog[5][3] = imm_form(3, 1, 6'h04, 0, 13'h104);  // Return lands here
		test_prog[5][4] = imm_form(3, 16, 6'h04, 0, 13'h108); // Link from jmpl
		test_prog[5][5] = branch_word(4'b1000, 22'd0);
		test_prog[5][7] = imm_form(3, 15, 6'h04, 0, 13'h100);
		test_prog[5][8] = imm_form(2, 16, 6'h38, 15, 13'h008); // jmpl r15+8 links r16
		test_prog[5][9] = imm_form(2, 1, 6'h02, 1, 13'h200);
		test_nst[5] = 3;
		exp_adr[5] = '{32'h100, 32'h104, 32'h108};
		exp_dat[5] = '{32'h004, 32'h244, 32'h020};
	endtask

	task automatic run_test(input int t);
		int  n;
		int  base;
		bit  bad;
		bad = 1'b0;
		@(posedge Clk);
		rst_req <= 1'b1;
		for (int k = 0; k < 256; k++)
			image[k] = {16'hdead, 6'b0, k[7:0], 2'b00};
		for (int w = 0; w < 10; w++)
			image[w] = test_prog[t][w];
		image[32] = test_data[t];    // Address 0x80
		@(posedge Clk);
		rst_req <= 1'b0;
		n = 0;
		while (!RESET && n < 10) begin
			@(negedge Clk);
			n++;
		end
		if (!RESET) begin
			$display("Test %s saw no RESET pulse", test_name[t]);
			bad = 1'b1;
		end
		n = 0;
		while (RESET && n < 20) begin
			@(negedge Clk);
			n++;
		end
		if (RESET) begin
			$display("Test %s timed out waiting for RESET to fall", test_name[t]);
			bad = 1'b1;
		end
		base = store_adr.size();
		n = 0;
		while (store_adr.size() < base + test_nst[t] && n < 3000) begin
			@(negedge Clk);
			n++;
		end
		if (store_adr.size() < base + test_nst[t]) begin
			$display("Test %s timed out waiting for its stores", test_name[t]);
			bad = 1'b1;
		end else begin
			for (int j = 0; j < test_nst[t]; j++) begin
				assert (store_adr[base+j] == exp_adr[t][j] &&
					store_dat[base+j] == exp_dat[t][j])
				else begin
					$display("Error at %0t: test %s store %0d wrote %h to %h, expected %h to %h",
						$time, test_name[t], j, store_dat[base+j], store_adr[base+j],
						exp_dat[t][j], exp_adr[t][j]);
					bad = 1'b1;
				end
			end
		end
		if (bad) begin
			n_fail++;
			$display("Test %s FAILED", test_name[t]);
		end else begin
			n_pass++;
			$display("Test %s passed", test_name[t]);
		end
	endtask

	initial begin
		for (int k = 0; k < 256; k++)
			image[k] = NOP;
		build_table();
		for (int t = 0; t < NTESTS; t++)
			run_test(t);
		$display("Passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	input  logic rst_req,    // Restarts the RESET pulse
	output logic Clk,
	output logic RESET
);

	logic [1:0] rst_cnt;

	initial begin
		Clk     = 1'b0;
		RESET   = 1'b1;
		rst_cnt = 2'd3;
	end

	always #20 Clk = ~Clk;    // 40 ns period

	// RESET stays high for four rising edges
	always @(posedge Clk) begin
		if (rst_req) begin
			RESET   <= 1'b1;
			rst_cnt <= 2'd3;
		end else if (rst_cnt != 2'd0) begin
			rst_cnt <= rst_cnt - 2'd1;
		end else begin
			RESET <= 1'b0;
		end
	end

endmodule

`default_nettype wire
